// File: Bender.yml
package:
  name: mem_subsys

sources:
  - cpu_pkg.sv
  - bus_pkg.sv
  - lane_steer.sv
  - mem_stage.sv
  - data_ram.sv
  - mem_subsys.sv
  - target: test
    files:
      - tb_mem_subsys.sv

// File: all.f
cpu_pkg.sv
bus_pkg.sv
lane_steer.sv
mem_stage.sv
data_ram.sv
mem_subsys.sv
tb_mem_subsys.sv

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

  // single master request, held for the whole cycle
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;   // bit 3 is the msb lane
    logic        we;
    logic        cyc;
    logic        stb;   // one clock per access
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // instruction class, ir[31:28]
  typedef enum logic [3:0] {
    T_INH   = 4'h0,
    T_PUSH  = 4'h1,
    T_POP   = 4'h2,
    T_LOAD  = 4'h3,
    T_STORE = 4'h4,
    T_OTHER = 4'h5
  } ir_class_t;

  typedef enum logic [1:0] {
    SZ_WORD  = 2'd0,
    SZ_HALF  = 2'd1,
    SZ_BYTE  = 2'd2,
    SZ_WORD2 = 2'd3   // handled as a word
  } access_size_t;

  localparam logic [3:0] OP_PUSH      = 4'h0;
  localparam logic [3:0] OP_JSR       = 4'h1;
  localparam logic [3:0] OP_POP       = 4'h0;
  localparam logic [3:0] OP_RTS       = 4'h1;
  localparam logic [3:0] OP_TRAP      = 4'h5;
  localparam logic [3:0] OP_RTI_SHORT = 4'h1;

  typedef struct packed {
    logic [63:0] ir;
    logic [31:0] result;     // address or vector
    logic [31:0] reg_data1;  // store data, pop address
    logic [31:0] reg_data2;  // push data
    logic [31:0] sp_data;    // already decremented
    logic [31:0] pc;
    logic        pc_set;
    logic [1:0]  reg_write;
    logic [1:0]  sp_write;
    logic [3:0]  bank;
    logic        halt;
    logic        exc;
  } ex_mem_t;

  typedef struct packed {
    logic [31:0] result;
    logic [31:0] pc;
    logic        pc_set;
    logic [1:0]  reg_write;
    logic [3:0]  reg_write_addr;
    logic [31:0] sp_data;
    logic [1:0]  sp_write;
    logic [3:0]  bank;
    logic        halt;
    logic        exc;
    logic [63:0] ir;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram #(
  parameter int unsigned RAM_AW   = 8,
  parameter int unsigned ACK_WAIT = 2
) (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire bus_pkg::bus_req_t bus_i,
  output bus_pkg::bus_rsp_t      bus_o
);

  localparam int unsigned CW = $clog2(ACK_WAIT + 1);

  logic [31:0]       mem [2**RAM_AW];
  logic [RAM_AW-1:0] idx;
  logic [CW-1:0]     cnt;
  logic              fire;
  logic              ack_q;
  logic [31:0]       rdat_q;

  assign idx = bus_i.adr[RAM_AW+1:2];

  // ack goes out on the edge where the countdown runs out
  assign fire = (bus_i.cyc && bus_i.stb) ? (ACK_WAIT == 1) : (cnt == CW'(1));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cnt   <= '0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= fire;
      if (bus_i.cyc && bus_i.stb)
        cnt <= CW'(ACK_WAIT - 1);
      else if (cnt != '0)
        cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fire)
    begin
      rdat_q <= mem[idx];  // whole word, master picks lanes
      if (bus_i.we)
        for (int i = 0; i < 4; i++)
          if (bus_i.sel[i])
            mem[idx][8*i +: 8] <= bus_i.dat[8*i +: 8];
    end
  end

  assign bus_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

// File: lane_steer.sv
`timescale 1ns/100ps
`default_nettype none

module lane_steer (
  input  wire cpu_pkg::access_size_t size_i,
  input  wire [1:0]                  adr_lo_i,
  input  wire [31:0]                 store_dat_i,
  input  wire [31:0]                 load_dat_i,
  output logic [3:0]                 sel_o,
  output logic [31:0]                store_dat_o,
  output logic [31:0]                load_dat_o
);

  logic [31:0] byte_shifted;
  logic [31:0] half_shifted;

  // big endian, address 0 sits in bits 31:24
  assign byte_shifted = load_dat_i >> {~adr_lo_i, 3'b000};
  assign half_shifted = adr_lo_i[1] ? load_dat_i : (load_dat_i >> 16);

  always_comb
  begin
    case (size_i)
      cpu_pkg::SZ_HALF:
      begin
        sel_o       = adr_lo_i[1] ? 4'b0011 : 4'b1100;
        store_dat_o = {2{store_dat_i[15:0]}};  // both halves, sel picks one
        load_dat_o  = {16'h0, half_shifted[15:0]};
      end
      cpu_pkg::SZ_BYTE:
      begin
        sel_o       = 4'b1000 >> adr_lo_i;
        store_dat_o = {4{store_dat_i[7:0]}};
        load_dat_o  = {24'h0, byte_shifted[7:0]};
      end
      default:
      begin
        sel_o       = 4'hf;  // word and word2
        store_dat_o = store_dat_i;
        load_dat_o  = load_dat_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire cpu_pkg::ex_mem_t  ex_i,
  input  wire                    stall_i,
  output logic                   stall_o,
  output cpu_pkg::mem_wb_t       wb_o,
  output bus_pkg::bus_req_t      bus_o,
  input  wire bus_pkg::bus_rsp_t bus_i
);

  typedef enum logic [2:0] {
    S_IDLE, S_EXC, S_LOAD, S_STORE,
    S_PUSH, S_POP, S_JSR, S_RTS
  } state_t;

  state_t                state;
  state_t                state_next;
  cpu_pkg::ir_class_t    ir_class;
  logic [3:0]            ir_op;
  logic                  ir_size;
  cpu_pkg::access_size_t ir_sz;
  cpu_pkg::access_size_t lat_size;
  logic [3:0]            req_sel;
  logic [31:0]           req_dat;
  logic [31:0]           load_dat;
  bus_pkg::bus_req_t     req_next;
  cpu_pkg::mem_wb_t      wb_next;

  assign ir_class = cpu_pkg::ir_class_t'(ex_i.ir[31:28]);
  assign ir_op    = ex_i.ir[27:24];
  assign ir_size  = ex_i.ir[0];   // long instruction flag
  assign ir_sz    = cpu_pkg::access_size_t'(ex_i.ir[25:24]);

  lane_steer u_req_steer (
    .size_i      (ir_sz),
    .adr_lo_i    (ex_i.result[1:0]),
    .store_dat_i (ex_i.reg_data1),
    .load_dat_i  (32'h0),
    .sel_o       (req_sel),
    .store_dat_o (req_dat),
    .load_dat_o  ()
  );

  // read side uses what was latched when the cycle started
  lane_steer u_load_steer (
    .size_i      (lat_size),
    .adr_lo_i    (bus_o.adr[1:0]),
    .store_dat_i (32'h0),
    .load_dat_i  (bus_i.dat),
    .sel_o       (),
    .store_dat_o (),
    .load_dat_o  (load_dat)
  );

  always_comb
  begin
    state_next   = state;
    req_next     = bus_o;
    req_next.stb = 1'b0;
    wb_next      = wb_o;

    if (!(stall_i || stall_o))
    begin
      wb_next.reg_write      = ex_i.reg_write;
      wb_next.reg_write_addr = ex_i.ir[23:20];
      wb_next.sp_data        = ex_i.sp_data;
      wb_next.sp_write       = ex_i.sp_write;
      wb_next.bank           = ex_i.bank;
      wb_next.halt           = ex_i.halt;
      wb_next.exc            = ex_i.exc;
      wb_next.ir             = ex_i.ir;
    end
    if (!stall_i)
    begin
      wb_next.result = ex_i.result;
      wb_next.pc     = ex_i.pc;
      wb_next.pc_set = ex_i.pc_set;
    end

    case (state)
      S_IDLE:
        if (ex_i.exc)
        begin
          state_next   = S_EXC;
          req_next.we  = 1'b1;
          req_next.sel = 4'hf;
          req_next.adr = ex_i.sp_data;
          req_next.dat = ex_i.pc - (ir_size ? 32'd8 : 32'd4);
        end
        else
        begin
          case (ir_class)
            cpu_pkg::T_INH:
              if (ir_op == cpu_pkg::OP_TRAP || (ir_op == cpu_pkg::OP_RTI_SHORT && !ir_size))
              begin
                state_next   = S_EXC;
                req_next.we  = 1'b1;
                req_next.sel = 4'hf;
                req_next.adr = ex_i.sp_data;
                req_next.dat = ex_i.pc;
              end
            cpu_pkg::T_LOAD, cpu_pkg::T_STORE:
            begin
              state_next   = (ir_class == cpu_pkg::T_LOAD) ? S_LOAD : S_STORE;
              req_next.we  = (ir_class == cpu_pkg::T_STORE);
              req_next.sel = req_sel;
              req_next.adr = ex_i.result;
              req_next.dat = req_dat;
            end
            cpu_pkg::T_PUSH:
            begin
              state_next   = (ir_op == cpu_pkg::OP_PUSH) ? S_PUSH : S_JSR;
              req_next.we  = 1'b1;
              req_next.sel = 4'hf;
              req_next.adr = ex_i.sp_data;
              req_next.dat = (ir_op == cpu_pkg::OP_PUSH) ? ex_i.reg_data2 : ex_i.pc;
            end
            cpu_pkg::T_POP:
            begin
              state_next   = (ir_op == cpu_pkg::OP_POP) ? S_POP : S_RTS;
              req_next.we  = 1'b0;
              req_next.sel = 4'hf;
              req_next.adr = ex_i.reg_data1;  // sp before increment
              req_next.dat = ex_i.reg_data1;
            end
            default:
            begin
            end
          endcase
        end
      S_EXC:
        if (bus_i.ack)
        begin
          wb_next.pc       = ex_i.result;  // vector
          wb_next.pc_set   = 1'b1;
          wb_next.sp_write = 2'h3;
        end
      S_JSR:
        if (bus_i.ack)
        begin
          wb_next.pc     = ex_i.result;
          wb_next.pc_set = 1'b1;
        end
      S_RTS:
        if (bus_i.ack)
        begin
          wb_next.pc     = bus_i.dat;
          wb_next.pc_set = 1'b1;
        end
      S_LOAD:
        if (bus_i.ack)
          wb_next.result = load_dat;
      S_POP:
        if (bus_i.ack)
          wb_next.result = bus_i.dat;
      default:
      begin
      end
    endcase

    if (state == S_IDLE)
    begin
      req_next.cyc = (state_next != S_IDLE);
      req_next.stb = (state_next != S_IDLE);
    end
    else if (bus_i.ack)
    begin
      state_next   = S_IDLE;
      req_next.cyc = 1'b0;
      req_next.we  = 1'b0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state    <= S_IDLE;
      stall_o  <= 1'b0;
      bus_o    <= '0;
      wb_o     <= '0;
      lat_size <= cpu_pkg::SZ_WORD;
    end
    else
    begin
      state   <= state_next;
      stall_o <= (state_next != S_IDLE);
      bus_o   <= req_next;
      wb_o    <= wb_next;
      if (state == S_IDLE)
        lat_size <= ir_sz;
    end
  end

endmodule

`default_nettype wire

// File: mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys #(
  parameter int unsigned RAM_AW   = 8,
  parameter int unsigned ACK_WAIT = 2
) (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire cpu_pkg::ex_mem_t   ex_i,
  input  wire                     stall_i,
  output wire                     stall_o,
  output wire cpu_pkg::mem_wb_t   wb_o,
  output wire bus_pkg::bus_req_t  bus_o
);

  wire bus_pkg::bus_rsp_t bus_rsp;

  mem_stage u_mem_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .ex_i    (ex_i),
    .stall_i (stall_i),
    .stall_o (stall_o),
    .wb_o    (wb_o),
    .bus_o   (bus_o),   // also goes out for observation
    .bus_i   (bus_rsp)
  );

  data_ram #(
    .RAM_AW   (RAM_AW),
    .ACK_WAIT (ACK_WAIT)
  ) u_data_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus_i (bus_o),
    .bus_o (bus_rsp)
  );

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;

  localparam int ACK_WAIT    = 2;  // uut default
  localparam int RST_CYCLES  = 5;
  localparam int CYCLE_LIMIT = 40 * (ACK_WAIT + 4) + RST_CYCLES;

  logic                   clk;
  logic                   rst;
  cpu_pkg::ex_mem_t       ex;
  logic                   stall_dn;
  wire                    stall_up;
  wire cpu_pkg::mem_wb_t  wb;
  wire bus_pkg::bus_req_t bus;

  logic [31:0] lfsr;
  logic [7:0]  model [1024];  // byte model where the lowest address is the msb lane
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;
  int          bus_errs;
  int          cycle_cnt;
  int          stall_len;
  logic        prev_stb;
  logic        prev_cyc;
  logic        prev_ack;

  mem_subsys UUT (
    .clk_i   (clk),
    .rst_i   (rst),
    .ex_i    (ex),
    .stall_i (stall_dn),
    .stall_o (stall_up),
    .wb_o    (wb),
    .bus_o   (bus)
  );

  always #50 clk = ~clk;

  // fibonacci lfsr over x^32 + x^22 + x^2 + x + 1
  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      v    = {v[30:0], lfsr[31]};
      lfsr = {lfsr[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_adr(input cpu_pkg::access_size_t sz);
    case (sz)
      cpu_pkg::SZ_HALF: return rand_bits(9) << 1;
      cpu_pkg::SZ_BYTE: return rand_bits(10);
      default:          return rand_bits(8) << 2;
    endcase
  endfunction

  function automatic string size_name(input cpu_pkg::access_size_t sz);
    case (sz)
      cpu_pkg::SZ_HALF: return "half";
      cpu_pkg::SZ_BYTE: return "byte";
      default:          return "word";
    endcase
  endfunction

  // one sel bit per byte touched, counting down from the msb lane
  function automatic logic [3:0] lane_sel(input cpu_pkg::access_size_t sz, input logic [1:0] lo);
    logic [3:0] s;
    int         n;
    case (sz)
      cpu_pkg::SZ_HALF: n = 2;
      cpu_pkg::SZ_BYTE: n = 1;
      default:          n = 4;
    endcase
    s = '0;
    for (int j = 0; j < n; j++)
      s[3 - (lo + j)] = 1'b1;
    return s;
  endfunction

  function automatic logic [31:0] lane_dat(input cpu_pkg::access_size_t sz,
                                           input logic [1:0] lo, input logic [31:0] d);
    case (sz)
      cpu_pkg::SZ_HALF: return lo[1] ? {16'h0, d[15:0]} : {d[15:0], 16'h0};
      cpu_pkg::SZ_BYTE: return {24'h0, d[7:0]} << (8 * (3 - lo));
      default:          return d;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  function automatic logic [31:0] model_load(input cpu_pkg::access_size_t sz, input logic [9:0] a);
    case (sz)
      cpu_pkg::SZ_HALF: return {16'h0, model[a], model[a + 10'd1]};
      cpu_pkg::SZ_BYTE: return {24'h0, model[a]};
      default:          return {model[a], model[a + 10'd1], model[a + 10'd2], model[a + 10'd3]};
    endcase
  endfunction

  task automatic model_store(input cpu_pkg::access_size_t sz, input logic [9:0] a,
                             input logic [31:0] d);
    case (sz)
      cpu_pkg::SZ_HALF:
      begin
        model[a]         = d[15:8];
        model[a + 10'd1] = d[7:0];
      end
      cpu_pkg::SZ_BYTE:
        model[a] = d[7:0];
      default:
      begin
        model[a]         = d[31:24];
        model[a + 10'd1] = d[23:16];
        model[a + 10'd2] = d[15:8];
        model[a + 10'd3] = d[7:0];
      end
    endcase
  endtask

  function automatic cpu_pkg::ex_mem_t nop_ex();
    cpu_pkg::ex_mem_t e;
    e           = '0;
    e.ir[31:28] = cpu_pkg::T_OTHER;
    return e;
  endfunction

  task automatic check_val(input string test, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("FAIL %s %s expected %h actual %h", test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic bus_error(input string msg);
    $display("bus protocol error at %0t: %s", $time, msg);
    bus_errs++;
    test_errs++;
  endtask

  // starts on a falling edge and returns on the falling edge after ack
  task automatic run_access(input string name, input cpu_pkg::ex_mem_t e, input logic [31:0] adr,
                            input logic [3:0] sel, input logic we, input logic [31:0] dat);
    logic [31:0] m;
    m  = lane_mask(sel);
    ex = e;
    @(negedge clk);
    check_val(name, "stb", 32'd1, bus.stb);
    check_val(name, "adr", adr, bus.adr);
    check_val(name, "sel", sel, bus.sel);
    check_val(name, "we", we, bus.we);
    if (we)
      check_val(name, "dat", dat & m, bus.dat & m);
    while (stall_up)
      @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    ex = nop_ex();
    @(negedge clk);
    if (test_errs == 0)
    begin
      pass_cnt++;
      $display("ok   %s", name);
    end
    else
    begin
      fail_cnt++;
      $display("bad  %s, %0d checks failed", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic do_store(input cpu_pkg::access_size_t sz, input logic [31:0] adr,
                          input logic [31:0] dat);
    cpu_pkg::ex_mem_t e;
    string            name;
    e           = nop_ex();
    name        = $sformatf("store_%s", size_name(sz));
    e.ir[31:24] = {cpu_pkg::T_STORE, 2'b00, sz};
    e.result    = adr;
    e.reg_data1 = dat;
    model_store(sz, adr[9:0], dat);
    run_access(name, e, adr, lane_sel(sz, adr[1:0]), 1'b1, lane_dat(sz, adr[1:0], dat));
    finish_test(name);
  endtask

  task automatic do_load(input cpu_pkg::access_size_t sz, input logic [31:0] adr);
    cpu_pkg::ex_mem_t e;
    string            name;
    e           = nop_ex();
    name        = $sformatf("load_%s", size_name(sz));
    e.ir[31:24] = {cpu_pkg::T_LOAD, 2'b00, sz};
    e.result    = adr;
    run_access(name, e, adr, lane_sel(sz, adr[1:0]), 1'b0, 32'h0);
    check_val(name, "result", model_load(sz, adr[9:0]), wb.result);
    finish_test(name);
  endtask

  task automatic do_push(input logic [31:0] sp, input logic [31:0] dat);
    cpu_pkg::ex_mem_t e;
    e           = nop_ex();
    e.ir[31:24] = {cpu_pkg::T_PUSH, cpu_pkg::OP_PUSH};
    e.sp_data   = sp;
    e.reg_data2 = dat;
    model_store(cpu_pkg::SZ_WORD, sp[9:0], dat);
    run_access("push", e, sp, 4'hf, 1'b1, dat);
    finish_test("push");
  endtask

  task automatic do_pop(input logic [31:0] sp);
    cpu_pkg::ex_mem_t e;
    e           = nop_ex();
    e.ir[31:24] = {cpu_pkg::T_POP, cpu_pkg::OP_POP};
    e.reg_data1 = sp;
    run_access("pop", e, sp, 4'hf, 1'b0, 32'h0);
    check_val("pop", "result", model_load(cpu_pkg::SZ_WORD, sp[9:0]), wb.result);
    finish_test("pop");
  endtask

  task automatic do_jsr(input logic [31:0] sp, input logic [31:0] ret, input logic [31:0] tgt);
    cpu_pkg::ex_mem_t e;
    e           = nop_ex();
    e.ir[31:24] = {cpu_pkg::T_PUSH, cpu_pkg::OP_JSR};
    e.sp_data   = sp;
    e.pc        = ret;
    e.result    = tgt;
    model_store(cpu_pkg::SZ_WORD, sp[9:0], ret);
    run_access("jsr", e, sp, 4'hf, 1'b1, ret);
    check_val("jsr", "pc_set", 32'd1, wb.pc_set);
    check_val("jsr", "pc", tgt, wb.pc);
    finish_test("jsr");
  endtask

  task automatic do_rts(input logic [31:0] sp);
    cpu_pkg::ex_mem_t e;
    e           = nop_ex();
    e.ir[31:24] = {cpu_pkg::T_POP, cpu_pkg::OP_RTS};
    e.reg_data1 = sp;
    run_access("rts", e, sp, 4'hf, 1'b0, 32'h0);
    check_val("rts", "pc_set", 32'd1, wb.pc_set);
    check_val("rts", "pc", model_load(cpu_pkg::SZ_WORD, sp[9:0]), wb.pc);
    finish_test("rts");
  endtask

  task automatic do_exc(input logic [31:0] sp, input logic [31:0] pc, input logic [31:0] vec,
                        input logic long_ir);
    cpu_pkg::ex_mem_t e;
    logic [31:0]      ret;
    e         = nop_ex();
    e.exc     = 1'b1;
    e.ir[0]   = long_ir;
    e.sp_data = sp;
    e.pc      = pc;
    e.result  = vec;
    ret       = pc - (long_ir ? 32'd8 : 32'd4);
    model_store(cpu_pkg::SZ_WORD, sp[9:0], ret);
    run_access("exception", e, sp, 4'hf, 1'b1, ret);
    check_val("exception", "pc", vec, wb.pc);
    check_val("exception", "pc_set", 32'd1, wb.pc_set);
    check_val("exception", "sp_write", 32'd3, wb.sp_write);
    finish_test("exception");
  endtask

  task automatic check_pass(input cpu_pkg::ex_mem_t e);
    check_val("passthrough_stall", "reg_write", e.reg_write, wb.reg_write);
    check_val("passthrough_stall", "bank", e.bank, wb.bank);
    check_val("passthrough_stall", "halt", e.halt, wb.halt);
    check_val("passthrough_stall", "reg_write_addr", e.ir[23:20], wb.reg_write_addr);
    check_val("passthrough_stall", "result", e.result, wb.result);
  endtask

  task automatic do_passthrough();
    cpu_pkg::ex_mem_t e;
    cpu_pkg::ex_mem_t first;
    e           = nop_ex();
    e.reg_write = 2'b10;
    e.bank      = 4'(rand_bits(4));
    e.halt      = 1'b1;
    e.ir[23:20] = 4'(rand_bits(4));
    e.result    = rand_bits(32);
    ex          = e;
    @(negedge clk);
    check_pass(e);
    first       = e;
    stall_dn    = 1'b1;
    e.reg_write = 2'b01;
    e.bank      = ~e.bank;
    e.halt      = 1'b0;
    e.ir[23:20] = ~e.ir[23:20];
    e.result    = ~e.result;
    ex          = e;
    repeat (2)
    begin
      @(negedge clk);
      check_pass(first);  // frozen by stall
    end
    stall_dn = 1'b0;
    @(negedge clk);
    check_pass(e);
    finish_test("passthrough_stall");
  endtask

  always @(negedge clk)
  begin
    if (rst)
    begin
      prev_stb  = 1'b0;
      prev_cyc  = 1'b0;
      prev_ack  = 1'b0;
      stall_len = 0;
    end
    else
    begin
      assert (!(bus.stb && prev_stb)) else bus_error("strobe high for more than one cycle");
      assert (!bus.stb || bus.cyc) else bus_error("strobe raised without cycle");
      assert (bus.cyc == stall_up) else bus_error("cycle and stall output disagree");
      if (prev_ack)
      begin
        assert (!bus.cyc) else bus_error("cycle still open after ack");
      end
      else if (prev_cyc)
      begin
        assert (bus.cyc) else bus_error("cycle dropped before ack");
      end
      if (stall_up)
        stall_len++;
      else if (stall_len != 0)
      begin
        assert (stall_len == ACK_WAIT + 1)
        else
          bus_error($sformatf("stall held %0d cycles, not %0d", stall_len, ACK_WAIT + 1));
        stall_len = 0;
      end
      prev_stb = bus.stb;
      prev_cyc = bus.cyc;
      prev_ack = UUT.bus_rsp.ack;
    end
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, run aborted", cycle_cnt);
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    cpu_pkg::access_size_t sz;
    logic [31:0]           adr;
    logic [31:0]           sp;
    clk       = 1'b0;
    rst       = 1'b1;
    stall_dn  = 1'b0;
    ex        = nop_ex();
    lfsr      = 32'd93963;
    test_errs = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    bus_errs  = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_val("reset", "cyc", 32'd0, bus.cyc);
    check_val("reset", "stb", 32'd0, bus.stb);
    check_val("reset", "pc_set", 32'd0, wb.pc_set);
    check_val("reset", "stall", 32'd0, stall_up);
    finish_test("reset");

    for (int r = 0; r < 2; r++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        sz  = cpu_pkg::access_size_t'(k);
        adr = rand_adr(sz);
        do_store(sz, adr, rand_bits(32));
        do_load(sz, adr);
      end
    end
    repeat (2)
    begin
      sp = rand_adr(cpu_pkg::SZ_WORD);
      do_push(sp, rand_bits(32));
      do_pop(sp);
    end
    sp = rand_adr(cpu_pkg::SZ_WORD);
    do_jsr(sp, rand_bits(32), rand_bits(32));
    do_rts(sp);
    for (int l = 0; l < 2; l++)
    begin
      sp = rand_adr(cpu_pkg::SZ_WORD);
      do_exc(sp, rand_bits(32), rand_bits(32), l[0]);  // short then long
      do_load(cpu_pkg::SZ_WORD, sp);
    end
    do_passthrough();

    $display("tests passed %0d, failed %0d, bus errors %0d", pass_cnt, fail_cnt, bus_errs);
    if (fail_cnt == 0 && bus_errs == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire
